// File: src/exec_pkg.sv
package exec_pkg;

  // cluster defaults, overridable through the top level parameters
  localparam int DATA_W  = 64;
  localparam int NUM_BUS = 4; // two lane buses, two external

  // flag bit positions
  localparam int FLAG_Z = 0;
  localparam int FLAG_S = 1;
  localparam int FLAG_C = 2;
  localparam int FLAG_V = 3;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [1:0]        bus_idx_t;
  typedef logic [3:0]        flags_t;

  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SHL = 3'd5,
    OP_SHR = 3'd6,
    OP_SAR = 3'd7
  } alu_op_t;

  // operand source select
  typedef enum logic [1:0] {
    FWD_REG  = 2'd0, // supplied value
    FWD_NOW  = 2'd1, // bus in the input cycle
    FWD_LAST = 2'd2  // bus one cycle earlier
  } fwd_mode_t;

endpackage

// File: src/alu_core.sv
`timescale 1ns/1ns
module alu_core import exec_pkg::*; #(
  parameter int DATA_W = exec_pkg::DATA_W
) (
  input  data_t   a,
  input  data_t   b,
  input  alu_op_t op,
  input  logic    is_sub,
  input  logic    size32,
  output data_t   result,
  output flags_t  flags
);

  localparam int HALF = DATA_W / 2;

  logic [DATA_W-1:0] b_eff;
  logic [DATA_W:0]   sum;
  logic [DATA_W-1:0] raw;
  logic              is_arith;
  logic              carry;
  logic              a_msb;
  logic              b_msb;
  logic              r_msb;

  assign b_eff = is_sub ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, b_eff} + {{DATA_W{1'b0}}, is_sub};

  always_comb begin
    case (op)
      OP_AND:  raw = a & b;
      OP_OR:   raw = a | b;
      OP_XOR:  raw = a ^ b;
      default: raw = sum[DATA_W-1:0];
    endcase
  end

  assign is_arith = (op == OP_ADD) || (op == OP_SUB);
  assign result   = size32 ? {{HALF{1'b0}}, raw[HALF-1:0]} : raw;

  // carry into the upper half recovered from the sum bit
  assign carry = size32 ? (sum[HALF] ^ a[HALF] ^ b_eff[HALF]) : sum[DATA_W];
  assign a_msb = size32 ? a[HALF-1] : a[DATA_W-1];
  assign b_msb = size32 ? b_eff[HALF-1] : b_eff[DATA_W-1];
  assign r_msb = size32 ? raw[HALF-1] : raw[DATA_W-1];

  always_comb begin
    flags         = '0;
    flags[FLAG_Z] = result == '0;
    flags[FLAG_S] = r_msb;
    flags[FLAG_C] = is_arith && (carry ^ is_sub); // borrow on sub
    flags[FLAG_V] = is_arith && (a_msb == b_msb) && (r_msb != a_msb);
  end

endmodule

// File: src/shift_unit.sv
`timescale 1ns/1ns
module shift_unit import exec_pkg::*; #(
  parameter int DATA_W = exec_pkg::DATA_W
) (
  input  data_t  a,
  input  data_t  b,
  input  logic   shift_right,
  input  logic   shift_arith,
  input  logic   size32,
  output data_t  result,
  output flags_t flags
);

  localparam int HALF  = DATA_W / 2;
  localparam int AMT_W = $clog2(DATA_W);

  logic [AMT_W-1:0]  amt;
  logic              fill;
  logic [DATA_W-1:0] src;
  logic [DATA_W:0]   right;
  logic [DATA_W-1:0] raw;

  assign amt  = size32 ? {1'b0, b[AMT_W-2:0]} : b[AMT_W-1:0]; // modulo size
  assign fill = shift_arith && (size32 ? a[HALF-1] : a[DATA_W-1]);
  assign src  = size32 ? {{HALF{fill}}, a[HALF-1:0]} : a;

  // extra top bit carries the fill into the shift
  assign right = $signed({fill, src}) >>> amt;
  assign raw   = shift_right ? right[DATA_W-1:0] : (a << amt);

  assign result = size32 ? {{HALF{1'b0}}, raw[HALF-1:0]} : raw;

  always_comb begin
    flags         = '0;
    flags[FLAG_Z] = result == '0;
    flags[FLAG_S] = size32 ? raw[HALF-1] : raw[DATA_W-1];
  end

endmodule

// File: src/op_decode.sv
`timescale 1ns/1ns
module op_decode import exec_pkg::*; #(
  parameter bit HAS_SHIFTER = 1'b1
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    en,
  input  alu_op_t op,
  input  logic    size32,
  output alu_op_t op_q,
  output logic    is_sub,
  output logic    is_shift,
  output logic    shift_right,
  output logic    shift_arith,
  output logic    size32_q,
  output logic    issue
);

  logic shift_op;

  assign shift_op = (op == OP_SHL) || (op == OP_SHR) || (op == OP_SAR);

  always_ff @(posedge clk) begin
    if (rst) begin
      op_q        <= OP_ADD;
      is_sub      <= 1'b0;
      is_shift    <= 1'b0;
      shift_right <= 1'b0;
      shift_arith <= 1'b0;
      size32_q    <= 1'b0;
      issue       <= 1'b0;
    end else begin
      op_q        <= op;
      is_sub      <= op == OP_SUB; // inverts b, carry-in of one
      is_shift    <= shift_op;
      shift_right <= (op == OP_SHR) || (op == OP_SAR);
      shift_arith <= op == OP_SAR;
      size32_q    <= size32;
      issue       <= en && (HAS_SHIFTER || !shift_op); // no shifter, no issue
    end
  end

endmodule

// File: src/operand_forward.sv
`timescale 1ns/1ns
module operand_forward import exec_pkg::*; #(
  parameter int DATA_W  = exec_pkg::DATA_W,
  parameter int NUM_BUS = exec_pkg::NUM_BUS
) (
  input  logic      clk,
  input  logic      rst,
  input  data_t     value,
  input  fwd_mode_t mode,
  input  bus_idx_t  bus_sel,
  input  data_t     buses [NUM_BUS],
  output data_t     operand_q
);

  data_t             bus_q [NUM_BUS];
  logic [DATA_W-1:0] pick;

  // history copy, one cycle behind the live buses
  always_ff @(posedge clk) begin
    bus_q <= buses;
  end

  always_comb begin
    case (mode)
      FWD_NOW:  pick = buses[bus_sel];
      FWD_LAST: pick = bus_q[bus_sel];
      default:  pick = value;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      operand_q <= '0;
    end else begin
      operand_q <= pick;
    end
  end

endmodule

// File: src/int_lane.sv
`timescale 1ns/1ns
module int_lane import exec_pkg::*; #(
  parameter int DATA_W      = exec_pkg::DATA_W,
  parameter int NUM_BUS     = exec_pkg::NUM_BUS,
  parameter bit HAS_SHIFTER = 1'b1
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      en,
  input  alu_op_t   op,
  input  logic      size32,
  input  data_t     a,
  input  data_t     b,
  input  fwd_mode_t a_mode,
  input  fwd_mode_t b_mode,
  input  bus_idx_t  a_bus,
  input  bus_idx_t  b_bus,
  input  data_t     buses [NUM_BUS],
  output data_t     result,
  output flags_t    flags,
  output logic      valid
);

  alu_op_t op_q;
  logic    is_sub;
  logic    is_shift;
  logic    shift_right;
  logic    shift_arith;
  logic    size32_q;
  logic    issue;
  data_t   a_q;
  data_t   b_q;
  data_t   alu_result;
  flags_t  alu_flags;
  data_t   sh_result;
  flags_t  sh_flags;

  op_decode #(.HAS_SHIFTER(HAS_SHIFTER)) decode_inst (
    .clk(clk), .rst(rst), .en(en), .op(op), .size32(size32),
    .op_q(op_q), .is_sub(is_sub), .is_shift(is_shift), .shift_right(shift_right),
    .shift_arith(shift_arith), .size32_q(size32_q), .issue(issue)
  );

  operand_forward #(.DATA_W(DATA_W), .NUM_BUS(NUM_BUS)) fwd_a_inst (
    .clk(clk), .rst(rst), .value(a), .mode(a_mode), .bus_sel(a_bus),
    .buses(buses), .operand_q(a_q)
  );

  operand_forward #(.DATA_W(DATA_W), .NUM_BUS(NUM_BUS)) fwd_b_inst (
    .clk(clk), .rst(rst), .value(b), .mode(b_mode), .bus_sel(b_bus),
    .buses(buses), .operand_q(b_q)
  );

  alu_core #(.DATA_W(DATA_W)) alu_inst (
    .a(a_q), .b(b_q), .op(op_q), .is_sub(is_sub), .size32(size32_q),
    .result(alu_result), .flags(alu_flags)
  );

  generate
    if (HAS_SHIFTER) begin : g_shift
      shift_unit #(.DATA_W(DATA_W)) shift_inst (
        .a(a_q), .b(b_q), .shift_right(shift_right), .shift_arith(shift_arith),
        .size32(size32_q), .result(sh_result), .flags(sh_flags)
      );
    end else begin : g_no_shift
      assign sh_result = '0; // never selected, issue drops shifts here
      assign sh_flags  = '0;
    end
  endgenerate

  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
      flags  <= '0;
      valid  <= 1'b0;
    end else begin
      valid <= issue;
      if (issue) begin // bus keeps last good value when idle
        result <= is_shift ? sh_result : alu_result;
        flags  <= is_shift ? sh_flags : alu_flags;
      end
    end
  end

endmodule

// File: src/exec_cluster.sv
`timescale 1ns/1ns
module exec_cluster import exec_pkg::*; #(
  parameter int DATA_W  = exec_pkg::DATA_W,
  parameter int NUM_BUS = exec_pkg::NUM_BUS
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      lane0_en,
  input  alu_op_t   lane0_op,
  input  logic      lane0_size32,
  input  data_t     lane0_a,
  input  data_t     lane0_b,
  input  fwd_mode_t lane0_a_mode,
  input  fwd_mode_t lane0_b_mode,
  input  bus_idx_t  lane0_a_bus,
  input  bus_idx_t  lane0_b_bus,
  output data_t     lane0_result,
  output flags_t    lane0_flags,
  output logic      lane0_valid,
  input  logic      lane1_en,
  input  alu_op_t   lane1_op,
  input  logic      lane1_size32,
  input  data_t     lane1_a,
  input  data_t     lane1_b,
  input  fwd_mode_t lane1_a_mode,
  input  fwd_mode_t lane1_b_mode,
  input  bus_idx_t  lane1_a_bus,
  input  bus_idx_t  lane1_b_bus,
  output data_t     lane1_result,
  output flags_t    lane1_flags,
  output logic      lane1_valid,
  input  data_t     ext_bus2,
  input  data_t     ext_bus3
);

  data_t buses [NUM_BUS];

  assign buses[0] = lane0_result;
  assign buses[1] = lane1_result;
  assign buses[2] = ext_bus2;
  assign buses[3] = ext_bus3;

  int_lane #(.DATA_W(DATA_W), .NUM_BUS(NUM_BUS), .HAS_SHIFTER(1'b0)) lane0_inst (
    .clk(clk), .rst(rst), .en(lane0_en), .op(lane0_op), .size32(lane0_size32),
    .a(lane0_a), .b(lane0_b), .a_mode(lane0_a_mode), .b_mode(lane0_b_mode),
    .a_bus(lane0_a_bus), .b_bus(lane0_b_bus), .buses(buses),
    .result(lane0_result), .flags(lane0_flags), .valid(lane0_valid)
  );

  // odd lane carries the shifter
  int_lane #(.DATA_W(DATA_W), .NUM_BUS(NUM_BUS), .HAS_SHIFTER(1'b1)) lane1_inst (
    .clk(clk), .rst(rst), .en(lane1_en), .op(lane1_op), .size32(lane1_size32),
    .a(lane1_a), .b(lane1_b), .a_mode(lane1_a_mode), .b_mode(lane1_b_mode),
    .a_bus(lane1_a_bus), .b_bus(lane1_b_bus), .buses(buses),
    .result(lane1_result), .flags(lane1_flags), .valid(lane1_valid)
  );

endmodule

// File: tb/exec_checker.sv
`timescale 1ns/1ns
module exec_checker import exec_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] exp_id,
  input  logic       exp0_valid,
  input  data_t      exp0_result,
  input  flags_t     exp0_flags,
  input  logic       exp1_valid,
  input  data_t      exp1_result,
  input  flags_t     exp1_flags,
  input  logic       lane0_valid,
  input  data_t      lane0_result,
  input  flags_t     lane0_flags,
  input  logic       lane1_valid,
  input  data_t      lane1_result,
  input  flags_t     lane1_flags,
  output int         errors,
  output int         checks,
  output int         tests
);

  // [stage][lane] with stage 1 lined up to the DUT output register
  logic [7:0] id_pipe [2];
  logic       val_pipe [2][2];
  data_t      res_pipe [2][2];
  flags_t     flg_pipe [2][2];
  logic       in_reset; // reset as seen on the rising edge
  logic [7:0] cur_id;
  int         test_errors;

  always @(posedge clk) begin
    in_reset <= rst;
    if (rst) begin
      for (int s = 0; s < 2; s++) begin
        id_pipe[s] <= '0;
        for (int l = 0; l < 2; l++) begin
          val_pipe[s][l] <= 1'b0;
          res_pipe[s][l] <= '0;
          flg_pipe[s][l] <= '0;
        end
      end
    end else begin
      id_pipe[0] <= exp_id;
      id_pipe[1] <= id_pipe[0];
      val_pipe[0][0] <= exp0_valid;
      val_pipe[0][1] <= exp1_valid;
      res_pipe[0][0] <= exp0_result;
      res_pipe[0][1] <= exp1_result;
      flg_pipe[0][0] <= exp0_flags;
      flg_pipe[0][1] <= exp1_flags;
      val_pipe[1] <= val_pipe[0];
      res_pipe[1] <= res_pipe[0];
      flg_pipe[1] <= flg_pipe[0];
    end
  end

  task automatic check_lane(input int lane, input logic act_valid, input data_t act_result,
                            input flags_t act_flags);
    checks++;
    if ((act_valid !== val_pipe[1][lane]) || (act_valid && ((act_result !== res_pipe[1][lane])
        || (act_flags !== flg_pipe[1][lane])))) begin
      $display("Mismatch at %0t ns: test %0d lane %0d got valid %0b result %h flags %h",
               $time, cur_id, lane, act_valid, act_result, act_flags);
      $display("  expected valid %0b result %h flags %h",
               val_pipe[1][lane], res_pipe[1][lane], flg_pipe[1][lane]);
      errors++;
      test_errors++;
    end
  endtask

  // outputs are stable on the falling edge
  always @(negedge clk) begin
    if (in_reset) begin
      errors = 0;
      checks = 0;
      tests = 0;
      test_errors = 0;
      cur_id = '0;
    end else begin
      if (id_pipe[1] != cur_id) begin
        if (cur_id != 0) begin
          tests++;
          $display("test %0d finished with %0d errors", cur_id, test_errors);
        end
        cur_id = id_pipe[1];
        test_errors = 0;
      end
      check_lane(0, lane0_valid, lane0_result, lane0_flags);
      check_lane(1, lane1_valid, lane1_result, lane1_flags);
    end
  end

endmodule

// File: tb/tb_exec_cluster.sv
`timescale 1ns/1ns
module tb_exec_cluster import exec_pkg::*; ();

  localparam int    PERIOD    = 4;
  localparam int    MAX_LINES = 1000;
  localparam string VEC_FILE  = "tb/exec_vectors.txt";

  logic      clk;
  logic      rst;
  logic      lane0_en, lane1_en;
  alu_op_t   lane0_op, lane1_op;
  logic      lane0_size32, lane1_size32;
  data_t     lane0_a, lane0_b, lane1_a, lane1_b;
  fwd_mode_t lane0_a_mode, lane0_b_mode, lane1_a_mode, lane1_b_mode;
  bus_idx_t  lane0_a_bus, lane0_b_bus, lane1_a_bus, lane1_b_bus;
  data_t     lane0_result, lane1_result;
  flags_t    lane0_flags, lane1_flags;
  logic      lane0_valid, lane1_valid;
  data_t     ext_bus2, ext_bus3;

  logic [7:0] exp_id;
  logic       exp0_valid, exp1_valid;
  data_t      exp0_result, exp1_result;
  flags_t     exp0_flags, exp1_flags;
  int         errors, checks, tests;

  int         seed;
  int         fd;
  int         n;
  int         lines;
  int         bad_lines;
  bit         done;
  string      line;
  logic [7:0] v_id;
  logic       v_en [2];
  logic [2:0] v_op [2];
  logic       v_sz [2];
  data_t      v_a [2];
  data_t      v_b [2];
  logic [1:0] v_am [2];
  logic [1:0] v_bm [2];
  logic [1:0] v_ab [2];
  logic [1:0] v_bb [2];
  data_t      v_e2, v_e3;
  data_t      v_res [2];
  logic [3:0] v_flg [2];
  logic       v_val [2];

  exec_cluster #(.DATA_W(64), .NUM_BUS(4)) exec_cluster_inst (.*);

  exec_checker checker_inst (
    .clk(clk), .rst(rst), .exp_id(exp_id),
    .exp0_valid(exp0_valid), .exp0_result(exp0_result), .exp0_flags(exp0_flags),
    .exp1_valid(exp1_valid), .exp1_result(exp1_result), .exp1_flags(exp1_flags),
    .lane0_valid(lane0_valid), .lane0_result(lane0_result), .lane0_flags(lane0_flags),
    .lane1_valid(lane1_valid), .lane1_result(lane1_result), .lane1_flags(lane1_flags),
    .errors(errors), .checks(checks), .tests(tests)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // idle lanes get random operands, never checked
  task automatic drive_idle();
    lane0_en = 1'b0;
    lane1_en = 1'b0;
    lane0_op = OP_ADD;
    lane1_op = OP_ADD;
    lane0_size32 = 1'b0;
    lane1_size32 = 1'b0;
    lane0_a = {$random(seed), $random(seed)};
    lane0_b = {$random(seed), $random(seed)};
    lane1_a = {$random(seed), $random(seed)};
    lane1_b = {$random(seed), $random(seed)};
    lane0_a_mode = FWD_REG;
    lane0_b_mode = FWD_REG;
    lane1_a_mode = FWD_REG;
    lane1_b_mode = FWD_REG;
    lane0_a_bus = '0;
    lane0_b_bus = '0;
    lane1_a_bus = '0;
    lane1_b_bus = '0;
    ext_bus2 = '0;
    ext_bus3 = '0;
    exp_id = '0;
    exp0_valid = 1'b0;
    exp1_valid = 1'b0;
    exp0_result = '0;
    exp1_result = '0;
    exp0_flags = '0;
    exp1_flags = '0;
  endtask

  task automatic apply_vector();
    lane0_en = v_en[0];
    lane1_en = v_en[1];
    lane0_op = alu_op_t'(v_op[0]);
    lane1_op = alu_op_t'(v_op[1]);
    lane0_size32 = v_sz[0];
    lane1_size32 = v_sz[1];
    lane0_a = v_en[0] ? v_a[0] : {$random(seed), $random(seed)};
    lane0_b = v_en[0] ? v_b[0] : {$random(seed), $random(seed)};
    lane1_a = v_en[1] ? v_a[1] : {$random(seed), $random(seed)};
    lane1_b = v_en[1] ? v_b[1] : {$random(seed), $random(seed)};
    lane0_a_mode = fwd_mode_t'(v_am[0]);
    lane0_b_mode = fwd_mode_t'(v_bm[0]);
    lane1_a_mode = fwd_mode_t'(v_am[1]);
    lane1_b_mode = fwd_mode_t'(v_bm[1]);
    lane0_a_bus = v_ab[0];
    lane0_b_bus = v_bb[0];
    lane1_a_bus = v_ab[1];
    lane1_b_bus = v_bb[1];
    ext_bus2 = v_e2;
    ext_bus3 = v_e3;
    exp_id = v_id;
    exp0_valid = v_val[0];
    exp1_valid = v_val[1];
    exp0_result = v_res[0];
    exp1_result = v_res[1];
    exp0_flags = v_flg[0];
    exp1_flags = v_flg[1];
  endtask

  initial begin
    #(PERIOD * (MAX_LINES + 100));
    $display("run did not finish within the time limit");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    seed = 32'h8d3c0227;
    lines = 0;
    bad_lines = 0;
    done = 1'b0;
    rst = 1'b1;
    drive_idle();
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("cannot open vector file %s", VEC_FILE);
      bad_lines = 1;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (fd != 0 && !done) begin
      if (lines > MAX_LINES) begin
        $display("vector file longer than %0d lines, stopping", MAX_LINES);
        bad_lines++;
        done = 1'b1;
      end else if ($fgets(line, fd) == 0) begin
        done = 1'b1;
      end else begin
        lines++;
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line,
            "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
            v_id, v_en[0], v_op[0], v_sz[0], v_a[0], v_b[0], v_am[0], v_bm[0],
            v_ab[0], v_bb[0], v_en[1], v_op[1], v_sz[1], v_a[1], v_b[1], v_am[1],
            v_bm[1], v_ab[1], v_bb[1], v_e2, v_e3, v_res[0], v_flg[0], v_val[0],
            v_res[1], v_flg[1], v_val[1]);
          if (n != 27) begin
            $display("vector line %0d has %0d fields instead of 27", lines, n);
            bad_lines++;
          end else begin
            @(negedge clk);
            apply_vector();
          end
        end
      end
    end
    repeat (4) begin // drain the pipeline
      @(negedge clk);
      drive_idle();
    end
    @(negedge clk);
    #1;
    if (fd != 0) $fclose(fd);
    $display("%0d tests, %0d checks, %0d errors, %0d bad vector lines",
             tests, checks, errors, bad_lines);
    if (errors == 0 && bad_lines == 0 && tests > 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: tb/exec_vectors.txt
# id | lane0: en op size32 a b a_mode b_mode a_bus b_bus | lane1: same | ext_bus2 ext_bus3
# | lane0 result flags valid | lane1 result flags valid   (all hex, ops 0..7, modes 0..2)
1 1 0 0 ffffffffffffffff 1 0 0 0 0 1 1 0 0 1 0 0 0 0 0 0 0 5 1 ffffffffffffffff 6 1
1 1 0 0 7fffffffffffffff 1 0 0 0 0 1 1 0 8000000000000000 1 0 0 0 0 0 0 8000000000000000 a 1 7fffffffffffffff 8 1
1 1 2 0 f0f0 ff00 0 0 0 0 1 3 0 f0f0 0f0f 0 0 0 0 0 0 f000 0 1 ffff 0 1
1 1 4 0 ffff ffff 0 0 0 0 1 4 0 8000000000000000 1 0 0 0 0 0 0 0 1 1 8000000000000001 2 1
1 1 1 0 5 3 0 0 0 0 1 0 0 3 4 0 0 0 0 0 0 2 0 1 7 0 1
2 1 0 1 ffffffff 1 0 0 0 0 1 1 1 0 1 0 0 0 0 0 0 0 5 1 ffffffff 6 1
2 1 0 1 123456787fffffff 1 0 0 0 0 1 2 1 ffffffffffff0000 ffff00000000ffff 0 0 0 0 0 0 80000000 a 1 0 1 1
2 1 4 1 aaaaaaaa55555555 5555555555555555 0 0 0 0 1 3 1 80000000 1 0 0 0 0 0 0 0 1 1 80000001 2 1
3 1 5 0 1 1 0 0 0 0 1 5 0 1 41 0 0 0 0 0 0 0 0 0 2 0 1
3 1 6 0 8000000000000000 1 0 0 0 0 1 6 0 8000000000000000 3f 0 0 0 0 0 0 0 0 0 1 0 1
3 1 7 0 8000000000000000 1 0 0 0 0 1 7 0 8000000000000000 4 0 0 0 0 0 0 0 0 0 f800000000000000 2 1
3 0 0 0 0 0 0 0 0 0 1 5 1 1 3f 0 0 0 0 0 0 0 0 0 80000000 2 1
3 0 0 0 0 0 0 0 0 0 1 6 1 ffffffff80000000 24 0 0 0 0 0 0 0 0 0 8000000 0 1
3 0 0 0 0 0 0 0 0 0 1 7 1 80000000 4 0 0 0 0 0 0 0 0 0 f8000000 2 1
4 1 0 0 10 20 0 0 0 0 1 0 0 100 1 0 0 0 0 1000 2000 30 0 1 101 0 1
4 1 0 0 0 0 1 2 2 3 0 0 0 0 0 0 0 0 0 1111 2222 3111 0 1 0 0 0
4 1 0 0 0 0 1 1 0 1 1 1 0 0 0 2 1 2 3 3 4 131 0 1 110d 0 1
4 1 0 0 0 0 2 1 0 0 1 4 0 0 101 2 0 1 0 0 0 3141 0 1 0 1 1
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0 0 1 0 0 0 0 1 2 0 1 0 0 0 0 0 424e 0 1
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// File: project.f
src/exec_pkg.sv
src/alu_core.sv
src/shift_unit.sv
src/op_decode.sv
src/operand_forward.sv
src/int_lane.sv
src/exec_cluster.sv
tb/exec_checker.sv
tb/tb_exec_cluster.sv

// File: Makefile
TOP := tb_exec_cluster
SRCS := $(shell grep -v '^+' project.f)

obj_dir/V$(TOP): project.f $(SRCS)
	verilator --binary --timing --top-module $(TOP) -f project.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	! grep -q "Simulation FAILED" sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
